// File: rtl/BypassControl.sv
//############################################################################
// Tracks the destinations of the two older ops in execute and write-back
// and picks a bypass source per operand, execute taking priority.
//############################################################################
`timescale 1ns/1ps

module BypassControl import IntPipePkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic stall,
    BypassIf.bypass bp
);

    logic exSlotValid;
    PRegNum exSlotReg;
    logic wbSlotValid;
    PRegNum wbSlotReg;

    // History moves one step per unstalled cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            exSlotValid <= 1'b0;
            exSlotReg <= '0;
            wbSlotValid <= 1'b0;
            wbSlotReg <= '0;
        end else if (!stall) begin
            exSlotValid <= bp.writeReg;
            exSlotReg <= bp.dstReg;
            wbSlotValid <= exSlotValid;
            wbSlotReg <= exSlotReg;
        end
    end

    function automatic BypassSel SelectSource(input PRegNum src, input logic readReg);
        if (!readReg || src == '0) begin
            return BYPASS_NONE;
        end else if (exSlotValid && src == exSlotReg) begin
            return BYPASS_EX;
        end else if (wbSlotValid && src == wbSlotReg) begin
            return BYPASS_WB;
        end else begin
            return BYPASS_NONE;
        end
    endfunction

    always_comb begin
        bp.bypassA = SelectSource(bp.srcRegA, bp.readRegA);
        bp.bypassB = SelectSource(bp.srcRegB, bp.readRegB);
    end

    // Immediate and PC operands must never pick up forwarded data
    assert property (@(posedge clk) disable iff (reset)
        !bp.readRegA |-> bp.bypassA == BYPASS_NONE)
    else
        $error("BypassControl: select on operand A without register read");

    assert property (@(posedge clk) disable iff (reset)
        !bp.readRegB |-> bp.bypassB == BYPASS_NONE)
    else
        $error("BypassControl: select on operand B without register read");

endmodule

// File: rtl/BypassIf.sv
//############################################################################
// Link between the register-read stage and the bypass controller.
// The stage reports its sources and destination, the controller answers
// with a bypass select per operand in the same cycle.
//############################################################################
`timescale 1ns/1ps

interface BypassIf import IntPipePkg::*; ();

    PRegNum srcRegA;
    PRegNum srcRegB;
    logic readRegA;
    logic readRegB;
    logic writeReg;
    PRegNum dstReg;
    BypassSel bypassA;
    BypassSel bypassB;

    modport stage (
        output srcRegA, srcRegB,
        output readRegA, readRegB,
        output writeReg, dstReg,
        input  bypassA, bypassB
    );

    modport bypass (
        input  srcRegA, srcRegB,
        input  readRegA, readRegB,
        input  writeReg, dstReg,
        output bypassA, bypassB
    );

endinterface

// File: rtl/IntPipePkg.sv
//############################################################################
// Shared widths, encodings and structs of the integer register-read stage.
// Modules and interfaces take these by a wildcard import in their header.
//############################################################################

package IntPipePkg;

    localparam int DATA_WIDTH = 32;
    localparam int PREG_NUM = 64;
    localparam int PREG_NUM_WIDTH = $clog2(PREG_NUM);
    localparam int ACTIVE_LIST_DEPTH = 16;
    localparam int ACTIVE_LIST_PTR_WIDTH = $clog2(ACTIVE_LIST_DEPTH);
    localparam int OPCODE_WIDTH = 4;
    localparam int IMM_WIDTH = 20;

    typedef logic [DATA_WIDTH-1:0] DataPath;
    typedef logic [PREG_NUM_WIDTH-1:0] PRegNum;
    typedef logic [ACTIVE_LIST_PTR_WIDTH-1:0] ActiveListPtr;

    // Operand source, encoding 2'b11 is unused
    typedef enum logic [1:0] {
        OOT_REG = 2'b00,
        OOT_IMM = 2'b01,
        OOT_PC  = 2'b10
    } OperandType;

    typedef enum logic {
        IMM_I = 1'b0,
        IMM_U = 1'b1
    } ImmType;

    typedef enum logic [1:0] {
        BYPASS_NONE = 2'b00,
        BYPASS_EX   = 2'b01,
        BYPASS_WB   = 2'b10
    } BypassSel;

    // Op as it leaves the issue queue
    typedef struct packed {
        logic [OPCODE_WIDTH-1:0] opCode;
        ActiveListPtr activeListPtr;
        PRegNum srcRegA;
        PRegNum srcRegB;
        PRegNum dstReg;
        logic writeReg;
        OperandType operandTypeA;
        OperandType operandTypeB;
        ImmType immType;
        logic [IMM_WIDTH-1:0] imm;
        DataPath pc;
    } IntIssueEntry;

    typedef struct packed {
        DataPath data;
        logic valid;
    } OperandWord;

    // Op handed to the execution stage
    typedef struct packed {
        logic valid;
        IntIssueEntry issue;
        OperandWord operandA;
        OperandWord operandB;
        BypassSel bypassA;
        BypassSel bypassB;
    } IntExecEntry;

    // Head inclusive, tail exclusive, equal pointers mean nothing to flush
    function automatic logic InFlushRange(
        input ActiveListPtr head,
        input ActiveListPtr tail,
        input ActiveListPtr ptr
    );
        if (head == tail) begin
            return 1'b0;
        end else if (head < tail) begin
            return (ptr >= head) && (ptr < tail);
        end else begin
            // Range wraps past the end of the active list
            return (ptr >= head) || (ptr < tail);
        end
    endfunction

endpackage

// File: rtl/IntRegReadStage.sv
//############################################################################
// Integer register-read stage. Holds the issued op for one cycle, reads
// its sources, builds the immediate, selects the operands and passes the
// op on with its bypass selects, subject to stall, clear and flush.
//############################################################################
`timescale 1ns/1ps

module IntRegReadStage import IntPipePkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic stall,
    input  logic clear,
    input  logic issueValid,
    input  IntIssueEntry issueEntry,
    input  logic recoveryFlush,
    input  logic flushAll,
    input  ActiveListPtr flushHead,
    input  ActiveListPtr flushTail,
    RegFileReadIf.stage regFile,
    BypassIf.stage bypass,
    output IntExecEntry execEntry
);

    // I-type sign-extends the field, U-type places it in the upper bits
    function automatic DataPath BuildImm(
        input ImmType immType,
        input logic [IMM_WIDTH-1:0] imm
    );
        if (immType == IMM_U) begin
            return {imm, {(DATA_WIDTH-IMM_WIDTH){1'b0}}};
        end else begin
            return {{(DATA_WIDTH-IMM_WIDTH){imm[IMM_WIDTH-1]}}, imm};
        end
    endfunction

    function automatic DataPath SelectOperand(
        input OperandType opType,
        input DataPath regValue,
        input DataPath immValue,
        input DataPath pcValue
    );
        case (opType)
            OOT_IMM: return immValue;
            OOT_PC:  return pcValue;
            default: return regValue;
        endcase
    endfunction

    logic pipeValid;
    IntIssueEntry pipeEntry;
    logic flush;
    logic outValid;
    DataPath immValue;
    OperandWord operandA;
    OperandWord operandB;

    // Pipeline register, payload carries no reset
    always_ff @(posedge clk) begin
        if (reset) begin
            pipeValid <= 1'b0;
        end else if (!stall) begin
            pipeValid <= issueValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pipeEntry <= issueEntry;
        end
    end

    // Selective flush by active-list range
    assign flush = recoveryFlush &&
        (flushAll || InFlushRange(flushHead, flushTail, pipeEntry.activeListPtr));
    assign outValid = pipeValid && !(stall || clear || reset || flush);

    // Sources and destination for register file and bypass controller
    always_comb begin
        regFile.srcRegA = pipeEntry.srcRegA;
        regFile.srcRegB = pipeEntry.srcRegB;

        bypass.srcRegA = pipeEntry.srcRegA;
        bypass.srcRegB = pipeEntry.srcRegB;
        bypass.readRegA = (pipeEntry.operandTypeA == OOT_REG);
        bypass.readRegB = (pipeEntry.operandTypeB == OOT_REG);
        // Only an op actually leaving the stage enters the bypass history
        bypass.writeReg = pipeEntry.writeReg && outValid;
        bypass.dstReg = pipeEntry.dstReg;
    end

    // Operand selection
    always_comb begin
        immValue = BuildImm(pipeEntry.immType, pipeEntry.imm);

        operandA.data = SelectOperand(pipeEntry.operandTypeA, regFile.dataA.data,
                                      immValue, pipeEntry.pc);
        operandB.data = SelectOperand(pipeEntry.operandTypeB, regFile.dataB.data,
                                      immValue, pipeEntry.pc);

        // Immediate and PC are always available
        operandA.valid = (pipeEntry.operandTypeA != OOT_REG) || regFile.dataA.valid;
        operandB.valid = (pipeEntry.operandTypeB != OOT_REG) || regFile.dataB.valid;
    end

    always_comb begin
        execEntry.valid = outValid;
        execEntry.issue = pipeEntry;
        execEntry.operandA = operandA;
        execEntry.operandB = operandB;
        execEntry.bypassA = bypass.bypassA;
        execEntry.bypassB = bypass.bypassB;
    end

    // Issue queue never sends the unused operand encoding
    assert property (@(posedge clk) disable iff (reset)
        pipeValid |-> (pipeEntry.operandTypeA inside {OOT_REG, OOT_IMM, OOT_PC}) &&
                      (pipeEntry.operandTypeB inside {OOT_REG, OOT_IMM, OOT_PC}))
    else
        $error("IntRegReadStage: unused operand type on a valid op");

endmodule

// File: rtl/IntRegReadTop.sv
//############################################################################
// Top level of the register-read block with plain ports. Connects the
// stage to the physical register file and the bypass controller.
// Issue fields go in, the op for the execution stage comes out.
//############################################################################
`timescale 1ns/1ps

module IntRegReadTop import IntPipePkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic stall,
    input  logic clear,
    input  logic issueValid,
    input  logic [OPCODE_WIDTH-1:0] issueOpCode,
    input  ActiveListPtr issueActiveListPtr,
    input  PRegNum issueSrcRegA,
    input  PRegNum issueSrcRegB,
    input  PRegNum issueDstReg,
    input  logic issueWriteReg,
    input  OperandType issueOperandTypeA,
    input  OperandType issueOperandTypeB,
    input  ImmType issueImmType,
    input  logic [IMM_WIDTH-1:0] issueImm,
    input  DataPath issuePc,
    input  logic recoveryFlush,
    input  logic flushAll,
    input  ActiveListPtr flushHead,
    input  ActiveListPtr flushTail,
    input  logic allocValid,
    input  PRegNum allocReg,
    input  logic wbValid,
    input  PRegNum wbReg,
    input  DataPath wbData,
    output logic exValid,
    output logic [OPCODE_WIDTH-1:0] exOpCode,
    output ActiveListPtr exActiveListPtr,
    output PRegNum exDstReg,
    output logic exWriteReg,
    output DataPath exOperandA,
    output logic exOperandAValid,
    output DataPath exOperandB,
    output logic exOperandBValid,
    output BypassSel exBypassA,
    output BypassSel exBypassB
);

    RegFileReadIf regFileIf ();
    BypassIf bypassIf ();

    IntIssueEntry issueEntry;
    IntExecEntry execEntry;

    assign issueEntry = '{
        opCode:        issueOpCode,
        activeListPtr: issueActiveListPtr,
        srcRegA:       issueSrcRegA,
        srcRegB:       issueSrcRegB,
        dstReg:        issueDstReg,
        writeReg:      issueWriteReg,
        operandTypeA:  issueOperandTypeA,
        operandTypeB:  issueOperandTypeB,
        immType:       issueImmType,
        imm:           issueImm,
        pc:            issuePc
    };

    IntRegReadStage i_stage (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .clear(clear),
        .issueValid(issueValid),
        .issueEntry(issueEntry),
        .recoveryFlush(recoveryFlush),
        .flushAll(flushAll),
        .flushHead(flushHead),
        .flushTail(flushTail),
        .regFile(regFileIf.stage),
        .bypass(bypassIf.stage),
        .execEntry(execEntry)
    );

    PhysRegFile i_regFile (
        .clk(clk),
        .reset(reset),
        .allocValid(allocValid),
        .allocReg(allocReg),
        .wbValid(wbValid),
        .wbReg(wbReg),
        .wbData(wbData),
        .rd(regFileIf.regFile)
    );

    BypassControl i_bypass (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .bp(bypassIf.bypass)
    );

    // Exec entry fields out to the plain ports
    assign exValid = execEntry.valid;
    assign exOpCode = execEntry.issue.opCode;
    assign exActiveListPtr = execEntry.issue.activeListPtr;
    assign exDstReg = execEntry.issue.dstReg;
    assign exWriteReg = execEntry.issue.writeReg;
    assign exOperandA = execEntry.operandA.data;
    assign exOperandAValid = execEntry.operandA.valid;
    assign exOperandB = execEntry.operandB.data;
    assign exOperandBValid = execEntry.operandB.valid;
    assign exBypassA = execEntry.bypassA;
    assign exBypassB = execEntry.bypassB;

endmodule

// File: rtl/PhysRegFile.sv
//############################################################################
// Physical register file with two combinational read ports and one write.
// Allocation clears a ready bit, write-back stores the data and sets it.
//############################################################################
`timescale 1ns/1ps

module PhysRegFile import IntPipePkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic allocValid,
    input  PRegNum allocReg,
    input  logic wbValid,
    input  PRegNum wbReg,
    input  DataPath wbData,
    RegFileReadIf.regFile rd
);

    DataPath regData [PREG_NUM];
    logic [PREG_NUM-1:0] ready;

    // Data storage
    always_ff @(posedge clk) begin
        if (wbValid) begin
            regData[wbReg] <= wbData;
        end
    end

    // Ready bits
    always_ff @(posedge clk) begin
        if (reset) begin
            ready <= '0;
        end else begin
            if (allocValid) begin
                ready[allocReg] <= 1'b0;
            end
            if (wbValid) begin
                ready[wbReg] <= 1'b1;
            end
        end
    end

    // Register 0 is hardwired, other registers show zero until written
    function automatic OperandWord ReadPort(input PRegNum num);
        OperandWord word;
        if (num == '0) begin
            word.data = '0;
            word.valid = 1'b1;
        end else begin
            word.data = ready[num] ? regData[num] : '0;
            word.valid = ready[num];
        end
        return word;
    endfunction

    always_comb begin
        rd.dataA = ReadPort(rd.srcRegA);
        rd.dataB = ReadPort(rd.srcRegB);
    end

    // A register is renamed only after its previous value has retired
    assert property (@(posedge clk) disable iff (reset)
        !(allocValid && wbValid && (allocReg == wbReg)))
    else
        $error("PhysRegFile: alloc and write-back on register %0d", allocReg);

endmodule

// File: rtl/RegFileReadIf.sv
//############################################################################
// Source read path between the register-read stage and the register file.
// Combinational read, each word carries the register's ready bit as valid.
//############################################################################
`timescale 1ns/1ps

interface RegFileReadIf import IntPipePkg::*; ();

    PRegNum srcRegA;
    PRegNum srcRegB;
    OperandWord dataA;
    OperandWord dataB;

    modport stage (
        output srcRegA,
        output srcRegB,
        input  dataA,
        input  dataB
    );

    modport regFile (
        input  srcRegA,
        input  srcRegB,
        output dataA,
        output dataB
    );

endinterface

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the result from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module IntRegReadTb \
    -f tb.f --Mdir obj_dir -o simv > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/simv > sim.log 2>&1 || echo "Simulator returned an error status"
cat sim.log

grep -q "SOME TESTS FAILED" sim.log && { echo "Run failed"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "Run ended without a result"; exit 1; }
exit 0

// File: tb.f
rtl/IntPipePkg.sv
rtl/RegFileReadIf.sv
rtl/BypassIf.sv
rtl/PhysRegFile.sv
rtl/BypassControl.sv
rtl/IntRegReadStage.sv
rtl/IntRegReadTop.sv
verif/TbClock.sv
verif/IntRegReadTb.sv

// File: verif/IntRegReadTb.sv
//############################################################################
// Directed testbench for the integer register-read block. Inputs change on
// the falling edge, each test task issues ops and checks what the top level
// hands to the execution stage. Results are counted and summed up at the end.
//############################################################################
`timescale 1ns/1ps

module IntRegReadTb import IntPipePkg::*; ();

    logic clk;
    logic reset;
    logic stall;
    logic clear;
    logic issueValid;
    logic [OPCODE_WIDTH-1:0] issueOpCode;
    ActiveListPtr issueActiveListPtr;
    PRegNum issueSrcRegA;
    PRegNum issueSrcRegB;
    PRegNum issueDstReg;
    logic issueWriteReg;
    OperandType issueOperandTypeA;
    OperandType issueOperandTypeB;
    ImmType issueImmType;
    logic [IMM_WIDTH-1:0] issueImm;
    DataPath issuePc;
    logic recoveryFlush;
    logic flushAll;
    ActiveListPtr flushHead;
    ActiveListPtr flushTail;
    logic allocValid;
    PRegNum allocReg;
    logic wbValid;
    PRegNum wbReg;
    DataPath wbData;
    logic exValid;
    logic [OPCODE_WIDTH-1:0] exOpCode;
    ActiveListPtr exActiveListPtr;
    PRegNum exDstReg;
    logic exWriteReg;
    DataPath exOperandA;
    logic exOperandAValid;
    DataPath exOperandB;
    logic exOperandBValid;
    BypassSel exBypassA;
    BypassSel exBypassB;

    int errors;
    int errorsAtStart;
    int testsRun;
    int testsFailed;
    string testName;
    // Values written back to registers 7 and 9, reused by later tests
    DataPath reg7Value;
    DataPath reg9Value;

    TbClock i_clock (.clk(clk));

    IntRegReadTop i_dut (.*);

    task automatic compareData(input string name, input DataPath exp, input DataPath act);
        if (exp !== act) begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic compareOperand(input string name, input OperandWord exp,
                                  input OperandWord act);
        if (exp !== act) begin
            $display("Mismatch at %0t: %s expected %h valid %b, got %h valid %b",
                     $time, name, exp.data, exp.valid, act.data, act.valid);
            errors++;
        end
    endtask

    task automatic compareBypass(input string name, input BypassSel exp, input BypassSel act);
        if (exp !== act) begin
            $display("Mismatch at %0t: %s expected %s, got %s (%0d)",
                     $time, name, exp.name(), act.name(), act);
            errors++;
        end
    endtask

    task automatic compareValid(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic beginTest(input string name);
        testName = name;
        errorsAtStart = errors;
    endtask

    task automatic endTest();
        testsRun++;
        if (errors == errorsAtStart) begin
            $display("Test %s: ok", testName);
        end else begin
            testsFailed++;
            $display("Test %s: %0d errors", testName, errors - errorsAtStart);
        end
    endtask

    // Register operands by default, random opcode, immediate and PC
    function automatic IntIssueEntry makeOp(input PRegNum srcA, input PRegNum srcB,
                                            input OperandType typeA, input OperandType typeB);
        IntIssueEntry op;
        op = '0;
        op.opCode = 4'($urandom);
        op.srcRegA = srcA;
        op.srcRegB = srcB;
        op.operandTypeA = typeA;
        op.operandTypeB = typeB;
        op.imm = 20'($urandom);
        op.pc = $urandom;
        return op;
    endfunction

    task automatic driveIssue(input IntIssueEntry op);
        @(negedge clk);
        issueValid = 1'b1;
        issueOpCode = op.opCode;
        issueActiveListPtr = op.activeListPtr;
        issueSrcRegA = op.srcRegA;
        issueSrcRegB = op.srcRegB;
        issueDstReg = op.dstReg;
        issueWriteReg = op.writeReg;
        issueOperandTypeA = op.operandTypeA;
        issueOperandTypeB = op.operandTypeB;
        issueImmType = op.immType;
        issueImm = op.imm;
        issuePc = op.pc;
    endtask

    task automatic idleCycle();
        @(negedge clk);
        issueValid = 1'b0;
    endtask

    // Samples 1 ns after the falling edge, well before the next rising edge
    task automatic waitExValid();
        int cycles;
        cycles = 0;
        #1;
        while (!exValid && cycles < 20) begin
            @(negedge clk);
            #1;
            cycles++;
        end
        if (!exValid) begin
            $display("Timeout at %0t: exValid did not rise within 20 cycles in test %s",
                     $time, testName);
            errors++;
        end
    endtask

    task automatic testRegisterOperands();
        beginTest("register operands");
        reg7Value = $urandom;
        reg9Value = $urandom;
        @(negedge clk);
        wbValid = 1'b1;
        wbReg = 6'd12;
        wbData = $urandom;
        @(negedge clk);
        wbReg = 6'd7;
        wbData = reg7Value;
        allocValid = 1'b1;
        allocReg = 6'd12;
        @(negedge clk);
        allocValid = 1'b0;
        wbReg = 6'd9;
        wbData = reg9Value;
        @(negedge clk);
        wbValid = 1'b0;
        driveIssue(makeOp(6'd7, 6'd9, OOT_REG, OOT_REG));
        idleCycle();
        waitExValid();
        compareOperand("exOperandA", {reg7Value, 1'b1}, {exOperandA, exOperandAValid});
        compareOperand("exOperandB", {reg9Value, 1'b1}, {exOperandB, exOperandBValid});
        // Register 12 was written, then allocated again and not yet written
        driveIssue(makeOp(6'd12, 6'd0, OOT_REG, OOT_REG));
        idleCycle();
        waitExValid();
        compareOperand("exOperandA", {32'h0, 1'b0}, {exOperandA, exOperandAValid});
        compareOperand("exOperandB", {32'h0, 1'b1}, {exOperandB, exOperandBValid});
        endTest();
    endtask

    task automatic testImmediatePc();
        IntIssueEntry op;
        beginTest("immediate and pc");
        op = makeOp(6'd12, 6'd12, OOT_IMM, OOT_PC);
        op.immType = IMM_I;
        op.imm = op.imm | 20'h80000;
        driveIssue(op);
        idleCycle();
        waitExValid();
        compareOperand("exOperandA", {12'hfff, op.imm, 1'b1}, {exOperandA, exOperandAValid});
        compareOperand("exOperandB", {op.pc, 1'b1}, {exOperandB, exOperandBValid});
        op = makeOp(6'd12, 6'd0, OOT_IMM, OOT_REG);
        op.immType = IMM_U;
        driveIssue(op);
        idleCycle();
        waitExValid();
        compareOperand("exOperandA", {op.imm, 12'h000, 1'b1}, {exOperandA, exOperandAValid});
        compareOperand("exOperandB", {32'h0, 1'b1}, {exOperandB, exOperandBValid});
        endTest();
    endtask

    task automatic testLatencyStall();
        IntIssueEntry op;
        beginTest("latency, stall and clear");
        op = makeOp(6'd7, 6'd9, OOT_REG, OOT_REG);
        driveIssue(op);
        idleCycle();
        #1;
        compareValid("exValid one cycle after issue", 1'b1, exValid);
        compareData("exOpCode", DataPath'(op.opCode), DataPath'(exOpCode));
        op = makeOp(6'd9, 6'd7, OOT_REG, OOT_REG);
        op.activeListPtr = 4'($urandom);
        op.dstReg = 6'd30;
        op.writeReg = 1'b1;
        driveIssue(op);
        idleCycle();
        stall = 1'b1;
        #1;
        compareValid("exValid under stall", 1'b0, exValid);
        @(negedge clk);
        #1;
        compareValid("exValid under stall", 1'b0, exValid);
        @(negedge clk);
        stall = 1'b0;
        waitExValid();
        compareData("exOpCode after stall", DataPath'(op.opCode), DataPath'(exOpCode));
        compareData("exActiveListPtr after stall", DataPath'(op.activeListPtr),
                    DataPath'(exActiveListPtr));
        compareData("exDstReg after stall", DataPath'(op.dstReg), DataPath'(exDstReg));
        compareValid("exWriteReg after stall", op.writeReg, exWriteReg);
        compareOperand("exOperandA", {reg9Value, 1'b1}, {exOperandA, exOperandAValid});
        compareOperand("exOperandB", {reg7Value, 1'b1}, {exOperandB, exOperandBValid});
        // Clear masks the held op, then the stage refills with nothing
        driveIssue(makeOp(6'd7, 6'd9, OOT_REG, OOT_REG));
        idleCycle();
        clear = 1'b1;
        #1;
        compareValid("exValid under clear", 1'b0, exValid);
        @(negedge clk);
        clear = 1'b0;
        #1;
        compareValid("exValid after clear", 1'b0, exValid);
        endTest();
    endtask

    // Range from 14 up to 3 wraps, so 14, 15, 0, 1 and 2 are flushed
    task automatic flushCase(input ActiveListPtr ptr, input logic all, input logic expected);
        IntIssueEntry op;
        op = makeOp(6'd7, 6'd9, OOT_REG, OOT_REG);
        op.activeListPtr = ptr;
        driveIssue(op);
        recoveryFlush = 1'b1;
        flushAll = all;
        flushHead = 4'd14;
        flushTail = 4'd3;
        idleCycle();
        #1;
        compareValid($sformatf("exValid ptr %0d flushAll %0b", ptr, all), expected, exValid);
        @(negedge clk);
        recoveryFlush = 1'b0;
        flushAll = 1'b0;
    endtask

    task automatic testSelectiveFlush();
        beginTest("selective flush");
        flushCase(4'd1, 1'b0, 1'b0);
        flushCase(4'd14, 1'b0, 1'b0);
        flushCase(4'd15, 1'b0, 1'b0);
        flushCase(4'd3, 1'b0, 1'b1);
        flushCase(4'd5, 1'b0, 1'b1);
        flushCase(4'd13, 1'b0, 1'b1);
        flushCase(4'd5, 1'b1, 1'b0);
        endTest();
    endtask

    task automatic testBypass();
        IntIssueEntry producer;
        IntIssueEntry consumer;
        IntIssueEntry zeroWriter;
        beginTest("bypass selection");
        producer = makeOp(6'd0, 6'd0, OOT_IMM, OOT_IMM);
        producer.dstReg = 6'd20;
        producer.writeReg = 1'b1;
        consumer = makeOp(6'd20, 6'd0, OOT_REG, OOT_REG);
        // An op writing register 0 goes first, so register 0 sits in write-back
        zeroWriter = makeOp(6'd0, 6'd0, OOT_IMM, OOT_IMM);
        zeroWriter.writeReg = 1'b1;
        driveIssue(zeroWriter);
        driveIssue(producer);
        driveIssue(consumer);
        idleCycle();
        waitExValid();
        compareBypass("exBypassA back to back", BYPASS_EX, exBypassA);
        compareBypass("exBypassB register 0", BYPASS_NONE, exBypassB);
        // One op without a destination between producer and consumer
        producer.dstReg = 6'd22;
        consumer = makeOp(6'd22, 6'd22, OOT_REG, OOT_IMM);
        driveIssue(producer);
        driveIssue(makeOp(6'd0, 6'd0, OOT_IMM, OOT_IMM));
        driveIssue(consumer);
        idleCycle();
        waitExValid();
        compareBypass("exBypassA one op between", BYPASS_WB, exBypassA);
        compareBypass("exBypassB immediate", BYPASS_NONE, exBypassB);
        // Register 22 is in the execute slot when reset starts, and stall
        // keeps the history frozen so that only reset can empty it
        driveIssue(producer);
        idleCycle();
        @(negedge clk);
        reset = 1'b1;
        stall = 1'b1;
        repeat (4) @(negedge clk);
        driveIssue(makeOp(6'd22, 6'd20, OOT_REG, OOT_REG));
        reset = 1'b0;
        stall = 1'b0;
        idleCycle();
        waitExValid();
        compareBypass("exBypassA after reset", BYPASS_NONE, exBypassA);
        compareBypass("exBypassB after reset", BYPASS_NONE, exBypassB);
        endTest();
    endtask

    initial begin
        void'($urandom(32'hf8e90cd9));
        errors = 0;
        errorsAtStart = 0;
        testsRun = 0;
        testsFailed = 0;
        reset = 1'b1;
        stall = 1'b0;
        clear = 1'b0;
        issueValid = 1'b0;
        issueOpCode = '0;
        issueActiveListPtr = '0;
        issueSrcRegA = '0;
        issueSrcRegB = '0;
        issueDstReg = '0;
        issueWriteReg = 1'b0;
        issueOperandTypeA = OOT_REG;
        issueOperandTypeB = OOT_REG;
        issueImmType = IMM_I;
        issueImm = '0;
        issuePc = '0;
        recoveryFlush = 1'b0;
        flushAll = 1'b0;
        flushHead = '0;
        flushTail = '0;
        allocValid = 1'b0;
        allocReg = '0;
        wbValid = 1'b0;
        wbReg = '0;
        wbData = '0;
        repeat (5) @(negedge clk);
        reset = 1'b0;

        testRegisterOperands();
        testImmediatePc();
        testLatencyStall();
        testSelectiveFlush();
        testBypass();

        @(negedge clk);
        $display("Tests run %0d, failed %0d, check errors %0d", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verif/TbClock.sv
//############################################################################
// Free-running testbench clock with an 8 ns period, starting low.
//############################################################################
`timescale 1ns/1ps

module TbClock (
    output logic clk
);

    initial clk = 1'b0;

    // Half period of 4 ns
    always #4 clk = ~clk;

endmodule
